//--- source/audmix_config.svh
// Width, register offset, glitch filter depth and settle time macros for the mixer

`ifndef AUDMIX_CONFIG_SVH
`define AUDMIX_CONFIG_SVH

//////////////////////////////
// Datapath widths
//////////////////////////////

// One audio sample
`define AUDMIX_SAMPLE_W 16

// Attenuation field, mute bit on top of a 4-bit shift
`define AUDMIX_ATT_W 5

//////////////////////////////
// Timing
//////////////////////////////

// Delay taps in the core sample glitch filter
`define AUDMIX_STAB_DEPTH 3

// Cycles after which the outputs follow held inputs
`define AUDMIX_SETTLE 12

//////////////////////////////
// Wishbone register map
//////////////////////////////

`define AUDMIX_WB_AW 4
`define AUDMIX_WB_DW 16

// Word offsets
`define AUDMIX_REG_VOLUME 0
`define AUDMIX_REG_MODE 1

`endif

//--- source/audmix_pkg.sv
// Audio sample, accumulator, attenuation and stereo mix mode types

`include "audmix_config.svh"

package audmix_pkg;

	//////////////////////////////
	// Sample path
	//////////////////////////////

	// Raw 16-bit sample, signedness depends on the source
	typedef logic [`AUDMIX_SAMPLE_W-1:0] sample_t;

	// One guard bit so that core plus host never wraps
	typedef logic signed [`AUDMIX_SAMPLE_W:0] acc_t;

	//////////////////////////////
	// Control
	//////////////////////////////

	// Top bit mutes, low bits give the right shift
	typedef logic [`AUDMIX_ATT_W-1:0] att_t;

	// How much of the other channel is folded in
	typedef enum logic [1:0] {
		MIX_NONE   = 2'd0,
		MIX_LIGHT  = 2'd1,
		MIX_MEDIUM = 2'd2,
		MIX_MONO   = 2'd3
	} mix_mode_t;

endpackage

//--- source/audmix_regs_pkg.sv
// Wishbone address and data types and the mixer register map

`include "audmix_config.svh"

package audmix_regs_pkg;

	//////////////////////////////
	// Bus types
	//////////////////////////////

	typedef logic [`AUDMIX_WB_AW-1:0] wb_addr_t;
	typedef logic [`AUDMIX_WB_DW-1:0] wb_data_t;

	//////////////////////////////
	// Register offsets
	//////////////////////////////

	// Attenuation and mute
	localparam wb_addr_t REG_VOLUME = wb_addr_t'(`AUDMIX_REG_VOLUME);

	// Mix mode in bits 1..0, signed core flag above it
	localparam wb_addr_t REG_MODE = wb_addr_t'(`AUDMIX_REG_MODE);

	// Position of the signed core flag in the MODE word
	localparam int MODE_SIGNED_BIT = 2;

endpackage

//--- source/audmix_wb_regs.sv
// Wishbone classic slave holding the volume and mode registers

`timescale 1ns/1ps

`include "audmix_config.svh"

module audmix_wb_regs (
	input  logic                        clk,
	input  logic                        resetd,

	input  logic                        i_wb_cyc,
	input  logic                        i_wb_stb,
	input  logic                        i_wb_we,
	input  audmix_regs_pkg::wb_addr_t   i_wb_adr,
	input  audmix_regs_pkg::wb_data_t   i_wb_dat,
	output audmix_regs_pkg::wb_data_t   o_wb_dat,
	output logic                        o_wb_ack,

	output audmix_pkg::att_t            o_att,
	output audmix_pkg::mix_mode_t       o_mix,
	output logic                        o_core_signed
);

	logic                      wb_req;
	audmix_regs_pkg::wb_data_t rd_data;

	// New cycle seen, ack not yet given
	assign wb_req = i_wb_cyc & i_wb_stb & ~o_wb_ack;

	//////////////////////////////
	// Read mux
	//////////////////////////////

	always_comb begin
		rd_data = '0;
		case (i_wb_adr)
			audmix_regs_pkg::REG_VOLUME: rd_data = audmix_regs_pkg::wb_data_t'(o_att);
			audmix_regs_pkg::REG_MODE: begin
				rd_data[1:0] = o_mix;
				rd_data[audmix_regs_pkg::MODE_SIGNED_BIT] = o_core_signed;
			end
			default: rd_data = '0;
		endcase
	end

	//////////////////////////////
	// Handshake and storage
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			o_wb_ack      <= 1'b0;
			o_wb_dat      <= '0;
			o_att         <= '0;
			o_mix         <= audmix_pkg::MIX_NONE;
			o_core_signed <= 1'b0;
		end else begin
			// Single-cycle ack, no wait states
			o_wb_ack <= wb_req;
			o_wb_dat <= rd_data;

			if (wb_req && i_wb_we) begin
				case (i_wb_adr)
					audmix_regs_pkg::REG_VOLUME: begin
						o_att <= audmix_pkg::att_t'(i_wb_dat[`AUDMIX_ATT_W-1:0]);
					end
					audmix_regs_pkg::REG_MODE: begin
						o_mix         <= audmix_pkg::mix_mode_t'(i_wb_dat[1:0]);
						o_core_signed <= i_wb_dat[audmix_regs_pkg::MODE_SIGNED_BIT];
					end
					default: ;
				endcase
			end
		end
	end

endmodule

//--- source/audmix_input_stage.sv
// Core sample glitch filter, format conversion and sum with the host sample

`timescale 1ns/1ps

`include "audmix_config.svh"

module audmix_input_stage (
	input  logic                clk,
	input  logic                resetd,

	input  logic                i_core_signed,
	input  audmix_pkg::sample_t i_core,
	input  audmix_pkg::sample_t i_host,

	output audmix_pkg::acc_t    o_sum,
	output audmix_pkg::sample_t o_pre
);

	audmix_pkg::sample_t taps [`AUDMIX_STAB_DEPTH];
	audmix_pkg::sample_t core_acc;
	audmix_pkg::acc_t    core_wide;
	audmix_pkg::acc_t    host_wide;

	//////////////////////////////
	// Glitch filter
	//////////////////////////////

	// Two oldest taps must agree before a new value is taken
	always_ff @(posedge clk) begin
		if (resetd) begin
			for (int i = 0; i < `AUDMIX_STAB_DEPTH; i++) begin
				taps[i] <= '0;
			end
			core_acc <= '0;
		end else begin
			taps[0] <= i_core;
			for (int i = 1; i < `AUDMIX_STAB_DEPTH; i++) begin
				taps[i] <= taps[i-1];
			end
			if (taps[`AUDMIX_STAB_DEPTH-2] == taps[`AUDMIX_STAB_DEPTH-1])
				core_acc <= taps[`AUDMIX_STAB_DEPTH-1];
		end
	end

	//////////////////////////////
	// Convert and sum
	//////////////////////////////

	// Unsigned core is halved so it fits next to a signed host sample
	assign core_wide = i_core_signed ? {core_acc[`AUDMIX_SAMPLE_W-1], core_acc}
	                                 : {2'b00, core_acc[`AUDMIX_SAMPLE_W-1:1]};
	assign host_wide = {i_host[`AUDMIX_SAMPLE_W-1], i_host};

	always_ff @(posedge clk) begin
		if (resetd) begin
			o_sum <= '0;
			o_pre <= '0;
		end else begin
			o_sum <= core_wide + host_wide;
			// Half level for the opposite channel
			o_pre <= o_sum[`AUDMIX_SAMPLE_W:1];
		end
	end

endmodule

//--- source/audmix_crossfeed.sv
// Stereo cross-feed of one channel against the other by mix mode

`timescale 1ns/1ps

`include "audmix_config.svh"

module audmix_crossfeed (
	input  logic                  clk,
	input  logic                  resetd,

	input  audmix_pkg::mix_mode_t i_mix,
	input  audmix_pkg::acc_t      i_sum,
	input  audmix_pkg::sample_t   i_pre_other,

	output audmix_pkg::acc_t      o_mixed
);

	audmix_pkg::acc_t pre_wide;
	audmix_pkg::acc_t mix_next;

	// Pre value from the other channel is signed
	assign pre_wide = {i_pre_other[`AUDMIX_SAMPLE_W-1], i_pre_other};

	//////////////////////////////
	// Mode select
	//////////////////////////////

	// All divisions are arithmetic shifts, result wraps at 17 bits
	always_comb begin
		case (i_mix)
			audmix_pkg::MIX_NONE: begin
				mix_next = i_sum;
			end
			audmix_pkg::MIX_LIGHT: begin
				mix_next = i_sum - (i_sum >>> 3) + (pre_wide >>> 2);
			end
			audmix_pkg::MIX_MEDIUM: begin
				mix_next = i_sum - (i_sum >>> 2) + (pre_wide >>> 1);
			end
			audmix_pkg::MIX_MONO: begin
				// Both channels end up at the same level
				mix_next = (i_sum >>> 1) + pre_wide;
			end
			default: begin
				mix_next = i_sum;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (resetd)
			o_mixed <= '0;
		else
			o_mixed <= mix_next;
	end

endmodule

//--- source/audmix_level.sv
// Attenuation, mute and saturation to the output sample width

`timescale 1ns/1ps

`include "audmix_config.svh"

module audmix_level (
	input  logic                clk,
	input  logic                resetd,

	input  audmix_pkg::att_t    i_att,
	input  audmix_pkg::acc_t    i_mixed,

	output audmix_pkg::sample_t o_out
);

	audmix_pkg::acc_t scaled;
	logic             ovf;

	// Top two bits differ when the value is out of 16-bit range
	assign ovf = scaled[`AUDMIX_SAMPLE_W] ^ scaled[`AUDMIX_SAMPLE_W-1];

	always_ff @(posedge clk) begin
		if (resetd) begin
			scaled <= '0;
			o_out  <= '0;
		end else begin
			// Stage 1: mute or shift down
			if (i_att[`AUDMIX_ATT_W-1])
				scaled <= '0;
			else
				scaled <= i_mixed >>> i_att[`AUDMIX_ATT_W-2:0];

			// Stage 2: clamp to full scale
			if (ovf)
				o_out <= {scaled[`AUDMIX_SAMPLE_W], {(`AUDMIX_SAMPLE_W-1){~scaled[`AUDMIX_SAMPLE_W]}}};
			else
				o_out <= scaled[`AUDMIX_SAMPLE_W-1:0];
		end
	end

endmodule

//--- source/audmix_top.sv
// Top level of the two-channel mixer with its Wishbone register block

`timescale 1ns/1ps

module audmix_top (
	input  logic                      clk,
	input  logic                      resetd,

	input  logic                      i_wb_cyc,
	input  logic                      i_wb_stb,
	input  logic                      i_wb_we,
	input  audmix_regs_pkg::wb_addr_t i_wb_adr,
	input  audmix_regs_pkg::wb_data_t i_wb_dat,
	output audmix_regs_pkg::wb_data_t o_wb_dat,
	output logic                      o_wb_ack,

	input  audmix_pkg::sample_t       i_core_left,
	input  audmix_pkg::sample_t       i_core_right,
	input  audmix_pkg::sample_t       i_host_left,
	input  audmix_pkg::sample_t       i_host_right,

	output audmix_pkg::sample_t       o_left,
	output audmix_pkg::sample_t       o_right
);

	audmix_pkg::att_t      att;
	audmix_pkg::mix_mode_t mix;
	logic                  core_signed;

	audmix_pkg::acc_t      sum_left;
	audmix_pkg::acc_t      sum_right;
	audmix_pkg::sample_t   pre_left;
	audmix_pkg::sample_t   pre_right;
	audmix_pkg::acc_t      mixed_left;
	audmix_pkg::acc_t      mixed_right;

	//////////////////////////////
	// Host registers
	//////////////////////////////

	audmix_wb_regs wb_regs_inst (
		.clk           (clk),
		.resetd        (resetd),
		.i_wb_cyc      (i_wb_cyc),
		.i_wb_stb      (i_wb_stb),
		.i_wb_we       (i_wb_we),
		.i_wb_adr      (i_wb_adr),
		.i_wb_dat      (i_wb_dat),
		.o_wb_dat      (o_wb_dat),
		.o_wb_ack      (o_wb_ack),
		.o_att         (att),
		.o_mix         (mix),
		.o_core_signed (core_signed)
	);

	//////////////////////////////
	// Left channel
	//////////////////////////////

	audmix_input_stage input_left_inst (
		.clk           (clk),
		.resetd        (resetd),
		.i_core_signed (core_signed),
		.i_core        (i_core_left),
		.i_host        (i_host_left),
		.o_sum         (sum_left),
		.o_pre         (pre_left)
	);

	// Right pre value feeds the left mix
	audmix_crossfeed crossfeed_left_inst (
		.clk         (clk),
		.resetd      (resetd),
		.i_mix       (mix),
		.i_sum       (sum_left),
		.i_pre_other (pre_right),
		.o_mixed     (mixed_left)
	);

	audmix_level level_left_inst (
		.clk     (clk),
		.resetd  (resetd),
		.i_att   (att),
		.i_mixed (mixed_left),
		.o_out   (o_left)
	);

	//////////////////////////////
	// Right channel
	//////////////////////////////

	audmix_input_stage input_right_inst (
		.clk           (clk),
		.resetd        (resetd),
		.i_core_signed (core_signed),
		.i_core        (i_core_right),
		.i_host        (i_host_right),
		.o_sum         (sum_right),
		.o_pre         (pre_right)
	);

	audmix_crossfeed crossfeed_right_inst (
		.clk         (clk),
		.resetd      (resetd),
		.i_mix       (mix),
		.i_sum       (sum_right),
		.i_pre_other (pre_left),
		.o_mixed     (mixed_right)
	);

	audmix_level level_right_inst (
		.clk     (clk),
		.resetd  (resetd),
		.i_att   (att),
		.i_mixed (mixed_right),
		.o_out   (o_right)
	);

endmodule

//--- sim/audmix_chk.sv
// Register shadow, output model and concurrent assertions for the mixer

`timescale 1ns/1ps

`include "audmix_config.svh"

module audmix_chk (
	input logic                      clk,
	input logic                      resetd,
	input logic                      i_wb_cyc,
	input logic                      i_wb_stb,
	input logic                      i_wb_we,
	input audmix_regs_pkg::wb_addr_t i_wb_adr,
	input audmix_regs_pkg::wb_data_t i_wb_dat,
	input audmix_regs_pkg::wb_data_t o_wb_dat,
	input logic                      o_wb_ack,
	input audmix_pkg::sample_t       i_core_left,
	input audmix_pkg::sample_t       i_core_right,
	input audmix_pkg::sample_t       i_host_left,
	input audmix_pkg::sample_t       i_host_right,
	input audmix_pkg::sample_t       o_left,
	input audmix_pkg::sample_t       o_right
);

	audmix_pkg::att_t          att_sh;
	audmix_pkg::mix_mode_t     mix_sh;
	logic                      sgn_sh;
	logic                      written;
	audmix_pkg::sample_t       core_ref_l;
	audmix_pkg::sample_t       core_ref_r;
	audmix_pkg::sample_t       core_prev_l;
	audmix_pkg::sample_t       core_prev_r;
	audmix_pkg::sample_t       host_prev_l;
	audmix_pkg::sample_t       host_prev_r;
	int                        held_cnt;
	int                        att_cnt;
	int unsigned               fail_count = 0;
	logic                      wr_req;
	logic                      new_core_l;
	logic                      new_core_r;
	logic                      host_chg;
	int                        sum_l;
	int                        sum_r;
	audmix_pkg::sample_t       exp_left;
	audmix_pkg::sample_t       exp_right;
	audmix_regs_pkg::wb_data_t exp_rd;

	//////////////////////////////
	// Output model
	//////////////////////////////

	// Widened core plus sign-extended host
	function automatic int sum_of(input logic sgn, input audmix_pkg::sample_t core,
		input audmix_pkg::sample_t host);
		int c;
		c = sgn ? int'($signed(core)) : int'(core >> 1);
		return c + int'($signed(host));
	endfunction

	// Own sum s against the other channel's half sum p
	function automatic int cross_of(input audmix_pkg::mix_mode_t mix, input int s, input int p);
		case (mix)
			audmix_pkg::MIX_LIGHT:  return s - (s >>> 3) + (p >>> 2);
			audmix_pkg::MIX_MEDIUM: return s - (s >>> 2) + (p >>> 1);
			audmix_pkg::MIX_MONO:   return (s >>> 1) + p;
			default:                return s;
		endcase
	endfunction

	function automatic audmix_pkg::sample_t level_of(input audmix_pkg::att_t att, input int m);
		int v;
		if (att[`AUDMIX_ATT_W-1])
			return '0;
		v = m >>> att[`AUDMIX_ATT_W-2:0];
		// Clamp to the signed 16-bit range
		if (v > 32767)
			v = 32767;
		else if (v < -32768)
			v = -32768;
		return audmix_pkg::sample_t'(v);
	endfunction

	always_comb begin
		// Host values as taken on the last edge, like the core reference
		sum_l     = sum_of(sgn_sh, core_ref_l, host_prev_l);
		sum_r     = sum_of(sgn_sh, core_ref_r, host_prev_r);
		exp_left  = level_of(att_sh, cross_of(mix_sh, sum_l, sum_r >>> 1));
		exp_right = level_of(att_sh, cross_of(mix_sh, sum_r, sum_l >>> 1));
		exp_rd    = '0;
		if (i_wb_adr == audmix_regs_pkg::REG_VOLUME)
			exp_rd[`AUDMIX_ATT_W-1:0] = att_sh;
		else if (i_wb_adr == audmix_regs_pkg::REG_MODE)
			exp_rd[2:0] = {sgn_sh, mix_sh};
	end

	//////////////////////////////
	// Shadow state
	//////////////////////////////

	assign wr_req     = i_wb_cyc & i_wb_stb & i_wb_we & ~o_wb_ack;
	// A core value counts once it is seen on two edges in a row
	assign new_core_l = (i_core_left != core_ref_l) && (i_core_left == core_prev_l);
	assign new_core_r = (i_core_right != core_ref_r) && (i_core_right == core_prev_r);
	assign host_chg   = (i_host_left != host_prev_l) || (i_host_right != host_prev_r);

	always_ff @(posedge clk) begin
		if (resetd) begin
			att_sh      <= '0;
			mix_sh      <= audmix_pkg::MIX_NONE;
			sgn_sh      <= 1'b0;
			written     <= 1'b0;
			core_ref_l  <= '0;
			core_ref_r  <= '0;
			core_prev_l <= '0;
			core_prev_r <= '0;
			host_prev_l <= '0;
			host_prev_r <= '0;
			held_cnt    <= 0;
			att_cnt     <= 0;
		end else begin
			core_prev_l <= i_core_left;
			core_prev_r <= i_core_right;
			host_prev_l <= i_host_left;
			host_prev_r <= i_host_right;
			if (new_core_l)
				core_ref_l <= i_core_left;
			if (new_core_r)
				core_ref_r <= i_core_right;
			if (wr_req) begin
				written <= 1'b1;
				if (i_wb_adr == audmix_regs_pkg::REG_VOLUME)
					att_sh <= i_wb_dat[`AUDMIX_ATT_W-1:0];
				if (i_wb_adr == audmix_regs_pkg::REG_MODE) begin
					mix_sh <= audmix_pkg::mix_mode_t'(i_wb_dat[1:0]);
					sgn_sh <= i_wb_dat[2];
				end
			end
			if (wr_req || new_core_l || new_core_r || host_chg)
				held_cnt <= 0;
			else if (held_cnt < 1000)
				held_cnt <= held_cnt + 1;
			if (wr_req && i_wb_adr == audmix_regs_pkg::REG_VOLUME)
				att_cnt <= 0;
			else if (att_cnt < 1000)
				att_cnt <= att_cnt + 1;
		end
	end

	//////////////////////////////
	// Assertions
	//////////////////////////////

	a_reset_quiet: assert property (@(posedge clk) disable iff (resetd)
		!written |-> !o_wb_ack && o_left == '0 && o_right == '0)
		else begin
			fail_count++;
			$error("Outputs or ack not idle before the first register write");
		end

	a_ack_single: assert property (@(posedge clk) disable iff (resetd)
		o_wb_ack |=> !o_wb_ack)
		else begin
			fail_count++;
			$error("Wishbone ack stayed high for more than one cycle");
		end

	a_ack_cause: assert property (@(posedge clk) disable iff (resetd)
		o_wb_ack |-> $past(i_wb_cyc && i_wb_stb))
		else begin
			fail_count++;
			$error("Wishbone ack without a preceding cycle and strobe");
		end

	a_read_data: assert property (@(posedge clk) disable iff (resetd)
		o_wb_ack && !i_wb_we |-> o_wb_dat == exp_rd)
		else begin
			fail_count++;
			$error("ERR %0t o_wb_dat expected %h got %h", $time,
				$sampled(exp_rd), $sampled(o_wb_dat));
		end

	a_left: assert property (@(posedge clk) disable iff (resetd)
		held_cnt >= `AUDMIX_SETTLE |-> o_left == exp_left)
		else begin
			fail_count++;
			$error("ERR %0t o_left expected %h got %h", $time,
				$sampled(exp_left), $sampled(o_left));
		end

	a_right: assert property (@(posedge clk) disable iff (resetd)
		held_cnt >= `AUDMIX_SETTLE |-> o_right == exp_right)
		else begin
			fail_count++;
			$error("ERR %0t o_right expected %h got %h", $time,
				$sampled(exp_right), $sampled(o_right));
		end

	// Muted output must not depend on the samples at all
	a_mute: assert property (@(posedge clk) disable iff (resetd)
		att_sh[`AUDMIX_ATT_W-1] && att_cnt >= `AUDMIX_SETTLE |-> o_left == '0 && o_right == '0)
		else begin
			fail_count++;
			$error("ERR %0t o_left/o_right expected 0000 0000 got %h %h", $time,
				$sampled(o_left), $sampled(o_right));
		end

endmodule

//--- sim/audmix_tb.sv
// Testbench for the mixer with clock, reset, Wishbone host tasks and scenario sequence

`timescale 1ns/1ps

`include "audmix_config.svh"

module audmix_tb;

	logic                      clk;
	logic                      resetd;
	logic                      i_wb_cyc;
	logic                      i_wb_stb;
	logic                      i_wb_we;
	audmix_regs_pkg::wb_addr_t i_wb_adr;
	audmix_regs_pkg::wb_data_t i_wb_dat;
	audmix_regs_pkg::wb_data_t o_wb_dat;
	logic                      o_wb_ack;
	audmix_pkg::sample_t       i_core_left;
	audmix_pkg::sample_t       i_core_right;
	audmix_pkg::sample_t       i_host_left;
	audmix_pkg::sample_t       i_host_right;
	audmix_pkg::sample_t       o_left;
	audmix_pkg::sample_t       o_right;
	int                        errors;
	int                        seed;

	audmix_top audmix_top_inst (.*);

	bind audmix_top audmix_chk chk_inst (.*);

	always #5 clk = ~clk;

	//////////////////////////////
	// Wishbone host
	//////////////////////////////

	// One classic cycle, read data is taken while ack is high
	task automatic bus_cycle(input logic we, input audmix_regs_pkg::wb_addr_t adr,
		input audmix_regs_pkg::wb_data_t dat, output audmix_regs_pkg::wb_data_t rdat);
		int wait_cnt;
		wait_cnt = 0;
		rdat     = '0;
		@(negedge clk);
		i_wb_cyc = 1'b1;
		i_wb_stb = 1'b1;
		i_wb_we  = we;
		i_wb_adr = adr;
		i_wb_dat = dat;
		do begin
			@(negedge clk);
			wait_cnt++;
		end while (!o_wb_ack && wait_cnt < 16);
		if (o_wb_ack) begin
			rdat = o_wb_dat;
			// Request stays up through the edge that samples ack
			@(negedge clk);
		end else begin
			errors++;
			$display("Wishbone ack did not arrive within %0d cycles at %0t", wait_cnt, $time);
		end
		i_wb_cyc = 1'b0;
		i_wb_stb = 1'b0;
		i_wb_we  = 1'b0;
	endtask

	task automatic write_reg(input audmix_regs_pkg::wb_addr_t adr,
		input audmix_regs_pkg::wb_data_t dat);
		audmix_regs_pkg::wb_data_t unused;
		bus_cycle(1'b1, adr, dat, unused);
	endtask

	task automatic read_reg(input audmix_regs_pkg::wb_addr_t adr,
		input audmix_regs_pkg::wb_data_t exp);
		audmix_regs_pkg::wb_data_t got;
		bus_cycle(1'b0, adr, '0, got);
		if (got !== exp) begin
			errors++;
			$display("ERR %0t o_wb_dat expected %h got %h", $time, exp, got);
		end
	endtask

	//////////////////////////////
	// Audio stimulus
	//////////////////////////////

	// Loud values sit next to the ends and the middle of the code range
	function automatic audmix_pkg::sample_t pick_sample(input logic loud);
		int r;
		r = $random(seed);
		if (loud)
			return audmix_pkg::sample_t'({r[1], {11{r[0]}}, r[5:2]});
		return r[15:0];
	endfunction

	task automatic drive_samples(input logic loud);
		@(negedge clk);
		i_core_left  = pick_sample(loud);
		i_core_right = pick_sample(loud);
		i_host_left  = pick_sample(loud);
		i_host_right = pick_sample(loud);
	endtask

	// Core input leaves its held value for exactly one cycle
	task automatic glitch_core(input logic right);
		audmix_pkg::sample_t held;
		@(negedge clk);
		held = right ? i_core_right : i_core_left;
		if (right)
			i_core_right = ~held;
		else
			i_core_left = ~held;
		@(negedge clk);
		if (right)
			i_core_right = held;
		else
			i_core_left = held;
		repeat (`AUDMIX_SETTLE + 2) @(negedge clk);
	endtask

	//////////////////////////////
	// Scenario
	//////////////////////////////

	initial begin
		int shifts [3];
		shifts       = '{0, 2, 7};
		seed         = 31;
		errors       = 0;
		clk          = 1'b0;
		resetd       = 1'b1;
		i_wb_cyc     = 1'b0;
		i_wb_stb     = 1'b0;
		i_wb_we      = 1'b0;
		i_wb_adr     = '0;
		i_wb_dat     = '0;
		i_core_left  = '0;
		i_core_right = '0;
		i_host_left  = '0;
		i_host_right = '0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		resetd = 1'b0;

		// Quiet outputs until the first write
		repeat (`AUDMIX_SETTLE + 2) @(negedge clk);

		// Read-back with unused bits set in the written words
		write_reg(audmix_regs_pkg::REG_VOLUME, 16'hffe3);
		read_reg(audmix_regs_pkg::REG_VOLUME, 16'h0003);
		write_reg(audmix_regs_pkg::REG_MODE, 16'hfff9);
		read_reg(audmix_regs_pkg::REG_MODE, 16'h0001);
		read_reg(4'h7, 16'h0000);

		// Every mode in both core formats at a few shifts
		for (int sgn = 0; sgn < 2; sgn++) begin
			for (int mode = 0; mode < 4; mode++) begin
				foreach (shifts[i]) begin
					write_reg(audmix_regs_pkg::REG_MODE,
						audmix_regs_pkg::wb_data_t'(sgn * 4 + mode));
					write_reg(audmix_regs_pkg::REG_VOLUME,
						audmix_regs_pkg::wb_data_t'(shifts[i]));
					read_reg(audmix_regs_pkg::REG_MODE,
						audmix_regs_pkg::wb_data_t'(sgn * 4 + mode));
					for (int k = 0; k < 3; k++) begin
						drive_samples(k == 0);
						repeat (`AUDMIX_SETTLE + 2) @(negedge clk);
					end
				end
			end
		end

		// Muted with samples changing on every cycle
		write_reg(audmix_regs_pkg::REG_VOLUME, 16'h0012);
		repeat (`AUDMIX_SETTLE + 20) drive_samples(1'b1);

		// Single-cycle glitches on held core inputs
		write_reg(audmix_regs_pkg::REG_VOLUME, 16'h0001);
		drive_samples(1'b0);
		repeat (`AUDMIX_SETTLE + 2) @(negedge clk);
		glitch_core(1'b0);
		glitch_core(1'b1);

		$display("Run complete: %0d testbench errors, %0d assertion failures",
			errors, audmix_top_inst.chk_inst.fail_count);
		if (errors == 0 && audmix_top_inst.chk_inst.fail_count == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

//--- filelist.f
+incdir+source
source/audmix_pkg.sv
source/audmix_regs_pkg.sv
source/audmix_wb_regs.sv
source/audmix_input_stage.sv
source/audmix_crossfeed.sv
source/audmix_level.sv
source/audmix_top.sv
sim/audmix_chk.sv
sim/audmix_tb.sv
